//--- design/texEnvPkg.sv
/* Texture environment package
   Color types, combine opcodes and mixer operand selects */
package texEnvPkg;

    // Width of one external color channel
    localparam int channelWidth = 8;

    // External RGBA8 color with red in the top byte
    typedef struct packed {
        logic [channelWidth-1:0] r;
        logic [channelWidth-1:0] g;
        logic [channelWidth-1:0] b;
        logic [channelWidth-1:0] a;
    } rgba8_t;

    // Combine functions of the texture environment
    typedef enum logic [2:0] {
        REPLACE     = 3'd0,
        MODULATE    = 3'd1,
        ADD         = 3'd2,
        SUBTRACT    = 3'd3,
        INTERPOLATE = 3'd4
    } combineOp_t;

    // What a mixer slot receives
    typedef enum logic [2:0] {
        TEXTURE            = 3'd0,
        PRIMARY            = 3'd1,
        CONSTANT           = 3'd2,
        ONE_MINUS_CONSTANT = 3'd3,
        ONE                = 3'd4,
        ZERO               = 3'd5
    } operandSrc_t;

    // Mixer computes srcA*srcB + srcC*srcD with srcD negated when negD is set
    typedef struct packed {
        operandSrc_t srcA;
        operandSrc_t srcB;
        operandSrc_t srcC;
        operandSrc_t srcD;
        logic        negD;
    } operandSel_t;

endpackage

//--- design/combinerControl.sv
/* Combiner control
   Holds opcode and constant color, decodes operand selects, delays valid */
`timescale 1ns/10ps

module combinerControl
    import texEnvPkg::*;
(
    input  logic        aclk,
    input  logic        rst,
    input  logic        cfgWrite,
    input  combineOp_t  cfgOp,
    input  rgba8_t      cfgConstant,
    input  logic        inValid,
    output operandSel_t opSel,
    output rgba8_t      constColor,
    output logic        outValid
);
    // Operand register, two mixer stages and the clamp
    localparam int pipeDepth = 4;

    combineOp_t           opReg;
    logic [pipeDepth-1:0] validPipe;

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            opReg      <= REPLACE;
            constColor <= '0;
        end
        else if (cfgWrite)
        begin
            opReg      <= cfgOp;
            constColor <= cfgConstant;
        end
    end

    // Default is texture*ONE + ZERO*ZERO
    always_comb
    begin
        opSel.srcA = TEXTURE;
        opSel.srcB = ONE;
        opSel.srcC = ZERO;
        opSel.srcD = ZERO;
        opSel.negD = 1'b0;
        case (opReg)
            MODULATE:
            begin
                opSel.srcB = PRIMARY;
            end
            ADD:
            begin
                opSel.srcC = PRIMARY;
                opSel.srcD = ONE;
            end
            SUBTRACT:
            begin
                opSel.srcC = PRIMARY;
                opSel.srcD = ONE;
                opSel.negD = 1'b1;
            end
            INTERPOLATE:
            begin
                opSel.srcB = CONSTANT;
                opSel.srcC = PRIMARY;
                opSel.srcD = ONE_MINUS_CONSTANT;
            end
            default:
            begin
                // Replace keeps the texture passthrough from the defaults
            end
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
            validPipe <= '0;
        else
            validPipe <= {validPipe[pipeDepth-2:0], inValid};
    end

    assign outValid = validPipe[pipeDepth-1];

endmodule

//--- design/operandSelect.sv
/* Operand select
   Widens input channels to signed and registers the four mixer operands */
`timescale 1ns/10ps

module operandSelect
    import texEnvPkg::*;
#(
    parameter int subPixelWidth = 9
) (
    input  logic                              aclk,
    input  operandSel_t                       opSel,
    input  rgba8_t                            texColor,
    input  rgba8_t                            primColor,
    input  rgba8_t                            constColor,
    output logic signed [4*subPixelWidth-1:0] colorA,
    output logic signed [4*subPixelWidth-1:0] colorB,
    output logic signed [4*subPixelWidth-1:0] colorC,
    output logic signed [4*subPixelWidth-1:0] colorD
);
    localparam int channels = 4;
    localparam logic signed [subPixelWidth-1:0] fixedOne =
        subPixelWidth'((1 << (subPixelWidth - 1)) - 1);

    logic signed [4*subPixelWidth-1:0] nextA;
    logic signed [4*subPixelWidth-1:0] nextB;
    logic signed [4*subPixelWidth-1:0] nextC;
    logic signed [4*subPixelWidth-1:0] nextD;

    // Zero extension keeps every input non-negative
    function automatic logic signed [subPixelWidth-1:0] widen(
        input logic [channelWidth-1:0] value
    );
        return {{(subPixelWidth - channelWidth){1'b0}}, value};
    endfunction

    function automatic logic signed [subPixelWidth-1:0] pick(
        input operandSrc_t                        src,
        input logic signed [subPixelWidth-1:0]    tex,
        input logic signed [subPixelWidth-1:0]    prim,
        input logic signed [subPixelWidth-1:0]    konst
    );
        logic signed [subPixelWidth-1:0] value;
        case (src)
            TEXTURE:            value = tex;
            PRIMARY:            value = prim;
            CONSTANT:           value = konst;
            ONE_MINUS_CONSTANT: value = fixedOne - konst;
            ONE:                value = fixedOne;
            default:            value = '0;
        endcase
        return value;
    endfunction

    always_comb
    begin : selectOperands
        logic signed [subPixelWidth-1:0] tex;
        logic signed [subPixelWidth-1:0] prim;
        logic signed [subPixelWidth-1:0] konst;
        logic signed [subPixelWidth-1:0] dValue;
        for (int ch = 0; ch < channels; ch++)
        begin
            tex   = widen(texColor[ch*channelWidth +: channelWidth]);
            prim  = widen(primColor[ch*channelWidth +: channelWidth]);
            konst = widen(constColor[ch*channelWidth +: channelWidth]);
            nextA[ch*subPixelWidth +: subPixelWidth] = pick(opSel.srcA, tex, prim, konst);
            nextB[ch*subPixelWidth +: subPixelWidth] = pick(opSel.srcB, tex, prim, konst);
            nextC[ch*subPixelWidth +: subPixelWidth] = pick(opSel.srcC, tex, prim, konst);
            dValue = pick(opSel.srcD, tex, prim, konst);
            // Negated slot D turns the sum into a difference
            nextD[ch*subPixelWidth +: subPixelWidth] = opSel.negD ? -dValue : dValue;
        end
    end

    always_ff @(posedge aclk)
    begin
        colorA <= nextA;
        colorB <= nextB;
        colorC <= nextC;
        colorD <= nextD;
    end

endmodule

//--- design/colorMixerSigned.sv
/* Signed color mixer
   Two-stage pipeline for colorA*colorB + colorC*colorD per channel,
   rounded and saturated to the signed channel range */
`timescale 1ns/10ps

module colorMixerSigned #(
    parameter int subPixelWidth = 9
) (
    input  logic                              aclk,
    input  logic signed [4*subPixelWidth-1:0] colorA,
    input  logic signed [4*subPixelWidth-1:0] colorB,
    input  logic signed [4*subPixelWidth-1:0] colorC,
    input  logic signed [4*subPixelWidth-1:0] colorD,
    output logic signed [4*subPixelWidth-1:0] mixedColor
);
    localparam int channels  = 4;
    localparam int prodWidth = 2 * (subPixelWidth - 1) + 1;
    // One extra bit for the carry of the product sum
    localparam int sumWidth  = prodWidth + 1;

    // One is also the largest signed channel value
    localparam logic signed [sumWidth-1:0] fixedOne =
        sumWidth'((1 << (subPixelWidth - 1)) - 1);
    localparam logic signed [sumWidth-1:0] satMin = -fixedOne - 1;

    logic signed [prodWidth-1:0] prodAB  [channels];
    logic signed [prodWidth-1:0] prodCD  [channels];
    logic signed [sumWidth-1:0]  rounded [channels];

    function automatic logic signed [subPixelWidth-1:0] saturate(
        input logic signed [sumWidth-1:0] value
    );
        logic signed [subPixelWidth-1:0] result;
        if (value > fixedOne)
            result = fixedOne[subPixelWidth-1:0];
        else if (value < satMin)
            result = satMin[subPixelWidth-1:0];
        else
            result = value[subPixelWidth-1:0];
        return result;
    endfunction

    // Stage 1 registers the eight channel products
    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channels; ch++)
        begin
            prodAB[ch] <= $signed(colorA[ch*subPixelWidth +: subPixelWidth])
                        * $signed(colorB[ch*subPixelWidth +: subPixelWidth]);
            prodCD[ch] <= $signed(colorC[ch*subPixelWidth +: subPixelWidth])
                        * $signed(colorD[ch*subPixelWidth +: subPixelWidth]);
        end
    end

    // Add the rounding term before scaling back down by one
    always_comb
    begin
        for (int ch = 0; ch < channels; ch++)
            rounded[ch] = (prodAB[ch] + prodCD[ch] + fixedOne) >>> (subPixelWidth - 1);
    end

    // Stage 2 saturates and registers the result
    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channels; ch++)
            mixedColor[ch*subPixelWidth +: subPixelWidth] <= saturate(rounded[ch]);
    end

endmodule

//--- design/colorClampUnsigned.sv
/* Unsigned color clamp
   Registers signed mixer channels clamped back into RGBA8 */
`timescale 1ns/10ps

module colorClampUnsigned
    import texEnvPkg::*;
#(
    parameter int subPixelWidth = 9
) (
    input  logic                              aclk,
    input  logic signed [4*subPixelWidth-1:0] mixedColor,
    output rgba8_t                            outColor
);
    localparam int channels = 4;
    localparam logic signed [subPixelWidth-1:0] channelMax =
        subPixelWidth'((1 << channelWidth) - 1);

    function automatic logic [channelWidth-1:0] clampChannel(
        input logic signed [subPixelWidth-1:0] value
    );
        logic [channelWidth-1:0] result;
        if (value < 0)
            result = '0;
        else if (value > channelMax)
            result = '1;
        else
            result = value[channelWidth-1:0];
        return result;
    endfunction

    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < channels; ch++)
        begin
            outColor[ch*channelWidth +: channelWidth] <=
                clampChannel($signed(mixedColor[ch*subPixelWidth +: subPixelWidth]));
        end
    end

endmodule

//--- design/texEnvCombiner.sv
/* Texture environment combiner
   Combines texture and primary color under the configured opcode,
   four cycles from input to output */
`timescale 1ns/10ps

module texEnvCombiner
    import texEnvPkg::*;
#(
    parameter int subPixelWidth = 9
) (
    input  logic       aclk,
    input  logic       rst,
    input  logic       cfgWrite,
    input  combineOp_t cfgOp,
    input  rgba8_t     cfgConstant,
    input  logic       inValid,
    input  rgba8_t     texColor,
    input  rgba8_t     primColor,
    output logic       outValid,
    output rgba8_t     outColor
);
    operandSel_t                       opSel;
    rgba8_t                            constColor;
    logic signed [4*subPixelWidth-1:0] colorA;
    logic signed [4*subPixelWidth-1:0] colorB;
    logic signed [4*subPixelWidth-1:0] colorC;
    logic signed [4*subPixelWidth-1:0] colorD;
    logic signed [4*subPixelWidth-1:0] mixedColor;

    combinerControl i_combinerControl (
        .aclk        (aclk),
        .rst         (rst),
        .cfgWrite    (cfgWrite),
        .cfgOp       (cfgOp),
        .cfgConstant (cfgConstant),
        .inValid     (inValid),
        .opSel       (opSel),
        .constColor  (constColor),
        .outValid    (outValid)
    );

    operandSelect #(
        .subPixelWidth (subPixelWidth)
    ) i_operandSelect (
        .aclk       (aclk),
        .opSel      (opSel),
        .texColor   (texColor),
        .primColor  (primColor),
        .constColor (constColor),
        .colorA     (colorA),
        .colorB     (colorB),
        .colorC     (colorC),
        .colorD     (colorD)
    );

    colorMixerSigned #(
        .subPixelWidth (subPixelWidth)
    ) i_colorMixerSigned (
        .aclk       (aclk),
        .colorA     (colorA),
        .colorB     (colorB),
        .colorC     (colorC),
        .colorD     (colorD),
        .mixedColor (mixedColor)
    );

    colorClampUnsigned #(
        .subPixelWidth (subPixelWidth)
    ) i_colorClampUnsigned (
        .aclk       (aclk),
        .mixedColor (mixedColor),
        .outColor   (outColor)
    );

endmodule

//--- tb/clockGen.sv
/* Testbench clock and reset
   40 ns clock with reset held for the first 10 cycles */
`timescale 1ns/10ps

module clockGen (
    output logic aclk,
    output logic rst
);
    localparam int halfPeriod  = 20;
    localparam int resetCycles = 10;

    initial
    begin
        aclk = 1'b0;
        forever #halfPeriod aclk = ~aclk;
    end

    initial
    begin
        rst <= 1'b1;
        repeat (resetCycles) @(posedge aclk);
        rst <= 1'b0;
    end

endmodule

//--- tb/texEnvCombinerTb.sv
/* Texture environment combiner testbench
   Random and corner fragments per opcode, checked against a reference model */
`timescale 1ns/10ps

module texEnvCombinerTb
    import texEnvPkg::*;
();
    localparam int subPixelWidth = 9;
    localparam int latency       = 4;

    logic        aclk;
    logic        rst;
    logic        cfgWrite;
    combineOp_t  cfgOp;
    rgba8_t      cfgConstant;
    logic        inValid;
    rgba8_t      texColor;
    rgba8_t      primColor;
    logic        outValid;
    rgba8_t      outColor;

    logic [31:0] seed;
    rgba8_t      expQueue[$];
    int          cycleQueue[$];
    int          cycleCount;
    int          dataErrors;
    int          latencyErrors;
    int          spuriousErrors;
    int          timeoutErrors;
    combineOp_t  modelOp;
    rgba8_t      modelConst;

    clockGen i_clockGen (
        .aclk (aclk),
        .rst  (rst)
    );

    texEnvCombiner #(
        .subPixelWidth (subPixelWidth)
    ) i_texEnvCombiner (
        .aclk        (aclk),
        .rst         (rst),
        .cfgWrite    (cfgWrite),
        .cfgOp       (cfgOp),
        .cfgConstant (cfgConstant),
        .inValid     (inValid),
        .texColor    (texColor),
        .primColor   (primColor),
        .outValid    (outValid),
        .outColor    (outColor)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rgba8_t randomColor();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Per channel product sum with rounding, shift, saturation and clamp to 0..255
    function automatic logic [7:0] expectChannel(
        input combineOp_t op,
        input int         t,
        input int         p,
        input int         k
    );
        int one;
        int sum;
        int r;
        one = (1 << (subPixelWidth - 1)) - 1;
        case (op)
            MODULATE:    sum = t * p;
            ADD:         sum = t * one + p * one;
            SUBTRACT:    sum = t * one - p * one;
            INTERPOLATE: sum = t * k + p * (one - k);
            default:     sum = t * one;
        endcase
        r = (sum + one) >>> (subPixelWidth - 1);
        if (r > one)
            r = one;
        if (r < -one - 1)
            r = -one - 1;
        if (r < 0)
            return 8'd0;
        if (r > 255)
            return 8'd255;
        return r[7:0];
    endfunction

    function automatic rgba8_t expectColor(
        input combineOp_t op,
        input rgba8_t     tex,
        input rgba8_t     prim,
        input rgba8_t     k
    );
        rgba8_t result;
        result.r = expectChannel(op, tex.r, prim.r, k.r);
        result.g = expectChannel(op, tex.g, prim.g, k.g);
        result.b = expectChannel(op, tex.b, prim.b, k.b);
        result.a = expectChannel(op, tex.a, prim.a, k.a);
        return result;
    endfunction

    // Each task drives one cycle of inputs
    task automatic sendFragment(input rgba8_t tex, input rgba8_t prim);
        @(posedge aclk);
        inValid   <= 1'b1;
        cfgWrite  <= 1'b0;
        texColor  <= tex;
        primColor <= prim;
    endtask

    task automatic writeConfig(input combineOp_t op, input rgba8_t k);
        @(posedge aclk);
        inValid     <= 1'b0;
        cfgWrite    <= 1'b1;
        cfgOp       <= op;
        cfgConstant <= k;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge aclk);
            inValid  <= 1'b0;
            cfgWrite <= 1'b0;
        end
    endtask

    task automatic waitForReset();
        int waited;
        waited = 0;
        while (rst !== 1'b0 && waited < 50)
        begin
            @(posedge aclk);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset was never released");
            timeoutErrors++;
        end
    endtask

    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (expQueue.size() > 0 && waited < 4 * latency)
        begin
            @(posedge aclk);
            waited++;
        end
        if (expQueue.size() > 0)
        begin
            $display("%0d fragments never came out of the combiner", expQueue.size());
            timeoutErrors++;
        end
    endtask

    // Reference model and output checks on the rising edge
    always @(posedge aclk)
    begin : monitor
        rgba8_t expected;
        int     accepted;
        cycleCount++;
        if (outValid === 1'b1)
        begin
            assert (expQueue.size() > 0)
            else
            begin
                $display("outValid went high at %0t with no fragment in flight", $time);
                spuriousErrors++;
            end
            if (expQueue.size() > 0)
            begin
                expected = expQueue.pop_front();
                accepted = cycleQueue.pop_front();
                assert (outColor === expected)
                else
                begin
                    $display("FAILED t=%0t outColor expected %h got %h",
                             $time, expected, outColor);
                    dataErrors++;
                end
                assert (cycleCount - accepted == latency)
                else
                begin
                    $display("FAILED t=%0t outValid latency expected %0d got %0d",
                             $time, latency, cycleCount - accepted);
                    latencyErrors++;
                end
            end
        end
        if (rst)
        begin
            modelOp    = REPLACE;
            modelConst = '0;
        end
        else
        begin
            // A fragment uses the configuration held before this edge
            if (inValid)
            begin
                expQueue.push_back(expectColor(modelOp, texColor, primColor, modelConst));
                cycleQueue.push_back(cycleCount);
            end
            if (cfgWrite)
            begin
                modelOp    = cfgOp;
                modelConst = cfgConstant;
            end
        end
    end

    initial
    begin : stimulus
        rgba8_t      tex;
        rgba8_t      prim;
        logic [2:0]  choice;
        cfgWrite    = 1'b0;
        cfgOp       = REPLACE;
        cfgConstant = '0;
        inValid     = 1'b0;
        texColor    = '0;
        primColor   = '0;
        seed        = 32'h88ab2ef4;
        cycleCount  = 0;

        waitForReset();
        idle(6);
        // Texture passes through before any configuration
        sendFragment(randomColor(), randomColor());
        sendFragment(32'hff00_80_01, randomColor());

        writeConfig(MODULATE, '0);
        repeat (20)
            sendFragment(randomColor(), randomColor());
        sendFragment(randomColor(), 32'hffffffff);

        writeConfig(ADD, '0);
        repeat (20)
            sendFragment(randomColor(), randomColor());
        sendFragment(32'hffffffff, 32'hffffffff);
        sendFragment(32'h80ff0001, 32'h80010000);

        writeConfig(SUBTRACT, '0);
        repeat (20)
            sendFragment(randomColor(), randomColor());
        sendFragment(32'h00000000, 32'hffffffff);
        sendFragment(32'hff7f0001, 32'h00800001);

        writeConfig(INTERPOLATE, randomColor());
        repeat (20)
            sendFragment(randomColor(), randomColor());
        writeConfig(INTERPOLATE, 32'h00000000);
        sendFragment(randomColor(), randomColor());
        writeConfig(INTERPOLATE, 32'hffffffff);
        sendFragment(randomColor(), randomColor());

        // Gaps in inValid with configuration changes between fragments
        for (int step = 0; step < 80; step++)
        begin
            seed   = xorshift(seed);
            choice = seed[2:0];
            if (choice == 3'd0)
                writeConfig(combineOp_t'(3'(seed[31:8] % 5)), randomColor());
            else if (choice < 3'd3)
                idle(1);
            else
            begin
                tex  = randomColor();
                prim = randomColor();
                sendFragment(tex, prim);
            end
        end
        idle(1);
        drainPipeline();
        idle(2);

        $display("Errors: data %0d, latency %0d, unexpected output %0d, timeout %0d",
                 dataErrors, latencyErrors, spuriousErrors, timeoutErrors);
        if (dataErrors + latencyErrors + spuriousErrors + timeoutErrors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- all.f
design/texEnvPkg.sv
design/combinerControl.sv
design/operandSelect.sv
design/colorMixerSigned.sv
design/colorClampUnsigned.sv
design/texEnvCombiner.sv
tb/clockGen.sv
tb/texEnvCombinerTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = texEnvCombinerTb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
